// File: include/fpu_cfg.svh
`ifndef FPU_CFG_SVH
`define FPU_CFG_SVH

// number of parallel multiply lanes.
`define FPU_LANES 4

`define FPU_TAGW 6

// decode takes one cycle and the lane takes two.
`define FPU_DEPTH 3

`endif

// File: source/fpu_pkg.sv
package fpu_pkg;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] fraction;
    } fp32_fields_t;

    // one binary32 word, seen as raw bits or as its fields.
    typedef union packed {
        logic [31:0]  raw;
        fp32_fields_t f;
    } fp32_t;

    typedef enum logic [1:0] {
        FP_ZERO   = 2'd0, // zero or a flushed subnormal.
        FP_NORMAL = 2'd1,
        FP_INF    = 2'd2,
        FP_NAN    = 2'd3
    } fp_class_t;

endpackage

// File: source/fp_operand_decode.sv
`timescale 1ns/1ns
`include "fpu_cfg.svh"

module fp_operand_decode
    import fpu_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             enable,
    input  logic [`FPU_LANES-1:0][31:0]      dataa,
    input  logic [`FPU_LANES-1:0][31:0]      datab,
    output fp_class_t [`FPU_LANES-1:0]       cls_a,
    output fp_class_t [`FPU_LANES-1:0]       cls_b,
    output logic [`FPU_LANES-1:0]            sign_a,
    output logic [`FPU_LANES-1:0]            sign_b,
    output logic [`FPU_LANES-1:0][7:0]       exp_a,
    output logic [`FPU_LANES-1:0][7:0]       exp_b,
    output logic [`FPU_LANES-1:0][23:0]      sig_a,
    output logic [`FPU_LANES-1:0][23:0]      sig_b
);

    function automatic fp_class_t classify(input fp32_t w);
        fp_class_t c;
        if (w.f.exponent == 8'hff) begin
            c = (w.f.fraction != 23'd0) ? FP_NAN : FP_INF;
        end else if (w.f.exponent == 8'h00) begin
            c = FP_ZERO; // subnormals are flushed to zero here.
        end else begin
            c = FP_NORMAL;
        end
        return c;
    endfunction

    function automatic logic [23:0] significand(input fp32_t w);
        logic [23:0] s;
        if (w.f.exponent != 8'h00 && w.f.exponent != 8'hff) begin
            s = {1'b1, w.f.fraction}; // restore the hidden bit.
        end else begin
            s = 24'd0;
        end
        return s;
    endfunction

    // class codes drive the special-case select in the lanes.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `FPU_LANES; i++) begin
                cls_a[i] <= FP_ZERO;
                cls_b[i] <= FP_ZERO;
            end
        end else if (enable) begin
            for (int i = 0; i < `FPU_LANES; i++) begin
                cls_a[i] <= classify(dataa[i]);
                cls_b[i] <= classify(datab[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            for (int i = 0; i < `FPU_LANES; i++) begin
                sign_a[i] <= dataa[i][31];
                sign_b[i] <= datab[i][31];
                exp_a[i]  <= dataa[i][30:23];
                exp_b[i]  <= datab[i][30:23];
                sig_a[i]  <= significand(dataa[i]);
                sig_b[i]  <= significand(datab[i]);
            end
        end
    end

endmodule

// File: source/fp_mul_lane.sv
`timescale 1ns/1ns

module fp_mul_lane
    import fpu_pkg::*;
(
    input  logic        clk,
    input  logic        enable,
    input  fp_class_t   cls_a,
    input  fp_class_t   cls_b,
    input  logic        sign_a,
    input  logic        sign_b,
    input  logic [7:0]  exp_a,
    input  logic [7:0]  exp_b,
    input  logic [23:0] sig_a,
    input  logic [23:0] sig_b,
    output logic [31:0] result
);

    localparam logic [31:0] QNAN = 32'h7fc00000;

    fp_class_t         cls_p;
    logic signed [9:0] exp_sum;

    fp_class_t         s1_cls;
    logic              s1_sign;
    logic signed [9:0] s1_exp;
    logic [47:0]       s1_prod;

    logic [23:0]       mant_pre;
    logic              guard;
    logic              sticky;
    logic              round_up;
    logic [24:0]       mant_rnd;
    logic [22:0]       frac_fin;
    logic signed [9:0] exp_norm;
    logic signed [9:0] exp_fin;
    fp32_t             res_word;

    // the class of the product decides whether the arithmetic path is used at all.
    always_comb begin
        if (cls_a == FP_NAN || cls_b == FP_NAN) begin
            cls_p = FP_NAN;
        end else if ((cls_a == FP_INF && cls_b == FP_ZERO) ||
                     (cls_a == FP_ZERO && cls_b == FP_INF)) begin
            cls_p = FP_NAN;
        end else if (cls_a == FP_INF || cls_b == FP_INF) begin
            cls_p = FP_INF;
        end else if (cls_a == FP_ZERO || cls_b == FP_ZERO) begin
            cls_p = FP_ZERO;
        end else begin
            cls_p = FP_NORMAL;
        end
    end

    assign exp_sum = $signed({2'b00, exp_a}) + $signed({2'b00, exp_b}) - 10'sd127;

    always_ff @(posedge clk) begin
        if (enable) begin
            s1_cls  <= cls_p;
            s1_sign <= sign_a ^ sign_b;
            s1_exp  <= exp_sum;
            s1_prod <= sig_a * sig_b;
        end
    end

    // the product of two 1.x values lies in [1, 4), so one shift is enough.
    always_comb begin
        if (s1_prod[47]) begin
            mant_pre = s1_prod[47:24];
            guard    = s1_prod[23];
            sticky   = |s1_prod[22:0];
        end else begin
            mant_pre = s1_prod[46:23];
            guard    = s1_prod[22];
            sticky   = |s1_prod[21:0];
        end
    end

    assign exp_norm = s1_exp + $signed({9'd0, s1_prod[47]});
    assign round_up = guard & (sticky | mant_pre[0]); // ties go to the even mantissa.
    assign mant_rnd = {1'b0, mant_pre} + {24'd0, round_up};

    // a carry out of rounding leaves 1.000..0 one binade up.
    assign exp_fin  = exp_norm + $signed({9'd0, mant_rnd[24]});
    assign frac_fin = mant_rnd[22:0];

    always_comb begin
        res_word.raw    = 32'd0;
        res_word.f.sign = s1_sign;
        case (s1_cls)
            FP_NAN: begin
                res_word.raw = QNAN;
            end
            FP_INF: begin
                res_word.f.exponent = 8'hff;
            end
            FP_ZERO: begin
                res_word.f.exponent = 8'h00;
            end
            default: begin
                if (exp_fin >= 10'sd255) begin
                    res_word.f.exponent = 8'hff; // overflow saturates to infinity.
                end else if (exp_fin <= 10'sd0) begin
                    res_word.f.exponent = 8'h00; // underflow flushes to signed zero.
                end else begin
                    res_word.f.exponent = exp_fin[7:0];
                    res_word.f.fraction = frac_fin;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            result <= res_word.raw;
        end
    end

    // Normal operands carry the hidden bit from decode, so the product is never below 1.
    a_prod_lead : assert property (@(posedge clk)
        (s1_cls == FP_NORMAL) |-> (s1_prod[47] || s1_prod[46]))
        else $error("product of normal operands lost its leading bit");

endmodule

// File: source/fp_tag_pipe.sv
`timescale 1ns/1ns
`include "fpu_cfg.svh"

module fp_tag_pipe (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid_in,
    input  logic [`FPU_TAGW-1:0] tag_in,
    input  logic                 ready_out,
    output logic                 valid_out,
    output logic [`FPU_TAGW-1:0] tag_out,
    output logic                 enable
);

    logic [`FPU_DEPTH-1:0]                valid_q;
    logic [`FPU_DEPTH-1:0][`FPU_TAGW-1:0] tag_q;
    logic                                 stall;

    assign stall   = valid_out & ~ready_out; // held result not yet taken.
    assign enable  = ~stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (enable) begin
            valid_q <= {valid_q[`FPU_DEPTH-2:0], valid_in};
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            tag_q <= {tag_q[`FPU_DEPTH-2:0], tag_in};
        end
    end

    assign valid_out = valid_q[`FPU_DEPTH-1];
    assign tag_out   = tag_q[`FPU_DEPTH-1];

    a_hold_out : assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> (valid_out && $stable(tag_out)))
        else $error("output changed while stalled");

    // Items further back in the pipe must not be dropped while the head waits.
    a_keep_valid : assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(valid_q))
        else $error("valid lost during stall");

endmodule

// File: source/fp_mul_unit.sv
`timescale 1ns/1ns
`include "fpu_cfg.svh"

module fp_mul_unit
    import fpu_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        valid_in,
    input  logic [`FPU_TAGW-1:0]        tag_in,
    input  logic [`FPU_LANES-1:0][31:0] dataa,
    input  logic [`FPU_LANES-1:0][31:0] datab,
    input  logic                        ready_out,
    output logic                        ready_in,
    output logic                        valid_out,
    output logic [`FPU_TAGW-1:0]        tag_out,
    output logic [`FPU_LANES-1:0][31:0] result
);

    logic                          enable;
    fp_class_t [`FPU_LANES-1:0]    cls_a;
    fp_class_t [`FPU_LANES-1:0]    cls_b;
    logic [`FPU_LANES-1:0]         sign_a;
    logic [`FPU_LANES-1:0]         sign_b;
    logic [`FPU_LANES-1:0][7:0]    exp_a;
    logic [`FPU_LANES-1:0][7:0]    exp_b;
    logic [`FPU_LANES-1:0][23:0]   sig_a;
    logic [`FPU_LANES-1:0][23:0]   sig_b;

    fp_operand_decode decode_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (enable),
        .dataa  (dataa),
        .datab  (datab),
        .cls_a  (cls_a),
        .cls_b  (cls_b),
        .sign_a (sign_a),
        .sign_b (sign_b),
        .exp_a  (exp_a),
        .exp_b  (exp_b),
        .sig_a  (sig_a),
        .sig_b  (sig_b)
    );

    for (genvar i = 0; i < `FPU_LANES; i++) begin : g_lane
        fp_mul_lane lane_i (
            .clk    (clk),
            .enable (enable),
            .cls_a  (cls_a[i]),
            .cls_b  (cls_b[i]),
            .sign_a (sign_a[i]),
            .sign_b (sign_b[i]),
            .exp_a  (exp_a[i]),
            .exp_b  (exp_b[i]),
            .sig_a  (sig_a[i]),
            .sig_b  (sig_b[i]),
            .result (result[i])
        );
    end

    fp_tag_pipe tag_pipe_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .tag_in    (tag_in),
        .ready_out (ready_out),
        .valid_out (valid_out),
        .tag_out   (tag_out),
        .enable    (enable)
    );

    assign ready_in = enable; // a request is taken whenever the pipe advances.

endmodule

// File: tests/fp_mul_tb.sv
`timescale 1ns/1ns
`include "fpu_cfg.svh"

module fp_mul_tb
    import fpu_pkg::*;
();

    typedef logic [`FPU_LANES-1:0][31:0] lanes_t;

    localparam int CLK_NS = 4;

    logic                 clk;
    logic                 rst_n;
    logic                 valid_in;
    logic [`FPU_TAGW-1:0] tag_in;
    lanes_t               dataa;
    lanes_t               datab;
    logic                 ready_out;
    logic                 ready_in;
    logic                 valid_out;
    logic [`FPU_TAGW-1:0] tag_out;
    lanes_t               result;

    logic [`FPU_TAGW-1:0] vec_tag[$];
    lanes_t               vec_a[$];
    lanes_t               vec_b[$];
    lanes_t               vec_res[$];
    logic [`FPU_TAGW-1:0] exp_tag_q[$];
    lanes_t               exp_res_q[$];

    logic [31:0] lfsr_state = 32'hcf7b_9afd;
    int          n_vec = 0;
    bit          loaded = 0;
    bit          pressure = 0;
    int          cycle = 0;
    int          rx_count = 0;
    int          lone_cycle = -1;

    fp_mul_unit dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .tag_in    (tag_in),
        .dataa     (dataa),
        .datab     (datab),
        .ready_out (ready_out),
        .ready_in  (ready_in),
        .valid_out (valid_out),
        .tag_out   (tag_out),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        forever begin
            @(negedge clk);
            cycle++;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1.
        end
        return s >> 1;
    endfunction

    function automatic logic take_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_step(lfsr_state);
        return b;
    endfunction

    task automatic report_mismatch(input string what);
        $display("Fail %0t ns: %s", $time, what);
        $display("tests failed");
        $fatal(1);
    endtask

    // operand lines and result lines alternate in the vector file.
    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] w [0:8];
        lanes_t      a;
        lanes_t      b;
        lanes_t      r;
        bit          want_ops;
        fd = $fopen("tests/fp_mul_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test vector file");
            $display("tests failed");
            $fatal(1);
        end
        want_ops = 1;
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.substr(0, 0) == "#") continue;
            if (want_ops) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                            w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7], w[8]);
                for (int l = 0; l < `FPU_LANES; l++) begin
                    a[l] = w[1 + 2 * l];
                    b[l] = w[2 + 2 * l];
                end
            end else begin
                n = $sscanf(line, "%h %h %h %h", r[0], r[1], r[2], r[3]);
            end
            if ((want_ops && n != 9) || (!want_ops && n != 4)) begin
                $display("a line in the test vector file could not be read");
                $display("tests failed");
                $fatal(1);
            end else if (!want_ops) begin
                vec_tag.push_back(w[0][`FPU_TAGW-1:0]);
                vec_a.push_back(a);
                vec_b.push_back(b);
                vec_res.push_back(r);
            end
            want_ops = !want_ops;
        end
        $fclose(fd);
    endtask

    // the request side also drives ready_out.
    initial begin
        int idx;
        bit b1;
        bit b2;
        rst_n     = 1'b0;
        valid_in  = 1'b0;
        tag_in    = '0;
        dataa     = '0;
        datab     = '0;
        ready_out = 1'b1;
        load_vectors();
        n_vec  = vec_tag.size();
        loaded = 1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        idx = 0;
        while (idx < n_vec) begin
            @(negedge clk);
            ready_out = pressure ? take_bit() : 1'b1;
            b1 = pressure ? take_bit() : 1'b1;
            b2 = pressure ? take_bit() : 1'b1;
            if (!b1 && !b2) begin
                valid_in = 1'b0; // idle gap.
            end else begin
                valid_in = 1'b1;
                tag_in   = vec_tag[idx];
                dataa    = vec_a[idx];
                datab    = vec_b[idx];
            end
            #1;
            if (valid_in && ready_in) begin
                exp_tag_q.push_back(vec_tag[idx]);
                exp_res_q.push_back(vec_res[idx]);
                if (idx == 0) lone_cycle = cycle;
                idx++;
                if (!pressure) begin
                    // the first request travels alone to measure latency.
                    while (rx_count < 1) begin
                        @(negedge clk);
                        valid_in = 1'b0;
                    end
                    pressure = 1;
                end
            end
        end
        @(negedge clk);
        valid_in = 1'b0;
        while (rx_count < n_vec) begin
            @(negedge clk);
            ready_out = take_bit();
        end
        @(negedge clk);
        ready_out = 1'b1;
        repeat (5) @(negedge clk);
        #1;
        if (rx_count == n_vec && !valid_out && ready_in) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("the pipeline did not drain to an idle state that accepts requests");
            $display("tests failed");
            $fatal(1);
        end
    end

    // result side.
    initial begin
        bit                   prev_stall;
        logic [`FPU_TAGW-1:0] prev_tag;
        lanes_t               prev_res;
        prev_stall = 0;
        wait (rst_n);
        forever begin
            @(negedge clk);
            #1;
            if (prev_stall) begin
                assert (valid_out && tag_out == prev_tag && result == prev_res)
                    else report_mismatch("output changed while held by the consumer");
            end
            if (valid_out && !ready_out) begin
                assert (!ready_in) else report_mismatch("ready_in high while output is held");
            end
            if (rx_count == 0) begin
                if (lone_cycle < 0 || cycle < lone_cycle + `FPU_DEPTH) begin
                    assert (!valid_out) else report_mismatch("valid_out high too early");
                end else begin
                    assert (valid_out && cycle == lone_cycle + `FPU_DEPTH)
                        else report_mismatch("first result not three cycles after request");
                end
            end
            if (valid_out && ready_out) begin
                assert (exp_tag_q.size() > 0) else report_mismatch("result with no request");
                assert (tag_out == exp_tag_q[0])
                    else report_mismatch($sformatf("tag expected %0h got %0h",
                                                   exp_tag_q[0], tag_out));
                for (int l = 0; l < `FPU_LANES; l++) begin
                    fp32_t g;
                    g.raw = result[l];
                    assert (g.raw == exp_res_q[0][l])
                        else report_mismatch($sformatf(
                            "lane %0d tag %0h expected %08h got %08h (exponent %02h)",
                            l, tag_out, exp_res_q[0][l], g.raw, g.f.exponent));
                end
                void'(exp_tag_q.pop_front());
                void'(exp_res_q.pop_front());
                rx_count++;
            end
            prev_stall = valid_out && !ready_out;
            prev_tag   = tag_out;
            prev_res   = result;
        end
    end

    initial begin
        wait (loaded);
        #((n_vec * 20 + 10 + 20) * CLK_NS);
        $display("results stopped arriving before every vector was checked");
        $display("tests failed");
        $fatal(1);
    end

endmodule

// File: list.f
+incdir+include
source/fpu_pkg.sv
source/fp_operand_decode.sv
source/fp_mul_lane.sv
source/fp_tag_pipe.sv
source/fp_mul_unit.sv
tests/fp_mul_tb.sv

// File: Makefile
TOP = fp_mul_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f list.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "all tests passed" sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: tests/fp_mul_tests.txt
# operand line: tag a0 b0 a1 b1 a2 b2 a3 b3 (hex, lane 0 first)
# result line: expected products r0 r1 r2 r3 (hex)
# exact products, rounding, specials, overflow and underflow
00 3F800000 3F800000 40000000 40400000 3FC00000 3FC00000 BF800000 40000000
3F800000 40C00000 40100000 C0000000
01 3F000000 3F000000 40400000 40400000 41200000 41200000 41200000 42C80000
3E800000 41100000 42C80000 447A0000
02 C0000000 C0400000 40800000 3E800000 3FC00000 40800000 3FC00000 C0000000
40C00000 3F800000 40C00000 C0400000
03 41200000 C2C80000 3F800001 3F800001 3F800001 3FC00000 3F800003 3FC00000
C47A0000 3F800002 3FC00002 3FC00004
04 3FFFFFFF 3FFFFFFF 3FFFFFFF 3F800001 3FFFFFFF 3F800002 3F800001 3F800003
407FFFFE 40000000 40000001 3F800004
05 7FC00000 3F800000 7F800001 40000000 FFC00000 3F800000 7F800000 00000000
7FC00000 7FC00000 7FC00000 7FC00000
06 00000000 FF800000 7F800000 40000000 7F800000 C0000000 FF800000 FF800000
7FC00000 7F800000 FF800000 7F800000
07 00000001 3F800000 80400000 3F800000 00400000 C0000000 00000001 7F800000
00000000 80000000 80000000 7FC00000
08 80000000 40000000 7F000000 40000000 7F7FFFFF 7F7FFFFF FF000000 40000000
80000000 7F800000 7F800000 FF800000
09 00800000 3F000000 00800000 BF000000 0D800000 0D800000 00800000 3F800000
00000000 80000000 00000000 00800000
0A 7F000000 3FFFFFFF 80000000 80000000 FF800000 80400000 C0000000 FF800000
7F7FFFFF 00000000 7FC00000 7F800000
0B 7F000000 3FC00000 3F000000 00800000 BF800000 BF800000 40000000 3F000000
7F400000 00000000 3F800000 3F800000
0C 3F800000 3F800000 40000000 40400000 3FC00000 3FC00000 BF800000 40000000
3F800000 40C00000 40100000 C0000000
0D 3F000000 3F000000 40400000 40400000 41200000 41200000 41200000 42C80000
3E800000 41100000 42C80000 447A0000
0E C0000000 C0400000 40800000 3E800000 3FC00000 40800000 3FC00000 C0000000
40C00000 3F800000 40C00000 C0400000
0F 41200000 C2C80000 3F800001 3F800001 3F800001 3FC00000 3F800003 3FC00000
C47A0000 3F800002 3FC00002 3FC00004
10 3FFFFFFF 3FFFFFFF 3FFFFFFF 3F800001 3FFFFFFF 3F800002 3F800001 3F800003
407FFFFE 40000000 40000001 3F800004
11 7FC00000 3F800000 7F800001 40000000 FFC00000 3F800000 7F800000 00000000
7FC00000 7FC00000 7FC00000 7FC00000
12 00000000 FF800000 7F800000 40000000 7F800000 C0000000 FF800000 FF800000
7FC00000 7F800000 FF800000 7F800000
13 00000001 3F800000 80400000 3F800000 00400000 C0000000 00000001 7F800000
00000000 80000000 80000000 7FC00000
14 80000000 40000000 7F000000 40000000 7F7FFFFF 7F7FFFFF FF000000 40000000
80000000 7F800000 7F800000 FF800000
15 00800000 3F000000 00800000 BF000000 0D800000 0D800000 00800000 3F800000
00000000 80000000 00000000 00800000
16 7F000000 3FFFFFFF 80000000 80000000 FF800000 80400000 C0000000 FF800000
7F7FFFFF 00000000 7FC00000 7F800000
17 7F000000 3FC00000 3F000000 00800000 BF800000 BF800000 40000000 3F000000
7F400000 00000000 3F800000 3F800000
18 3F800000 3F800000 40000000 40400000 3FC00000 3FC00000 BF800000 40000000
3F800000 40C00000 40100000 C0000000
19 41200000 C2C80000 3F800001 3F800001 3F800001 3FC00000 3F800003 3FC00000
C47A0000 3F800002 3FC00002 3FC00004
1A 7FC00000 3F800000 7F800001 40000000 FFC00000 3F800000 7F800000 00000000
7FC00000 7FC00000 7FC00000 7FC00000
1B 00800000 3F000000 00800000 BF000000 0D800000 0D800000 00800000 3F800000
00000000 80000000 00000000 00800000
